/* test/aer_stimulus.txt */
// Pixel events to raise, one per line as row, column and polarity
// Polarity 1 is ON, 2 is OFF and 3 is both. A line of dashes ends a batch
0 0 1
0 1 2
1 0 3
1 1 1
2 5 2
5 2 1
7 7 3
--
0 1 1
3 3 2
4 4 1
6 1 2
--
1 1 2
2 2 3
2 3 1
7 6 1
--
0 0 2
5 7 3

/* vlog.f */
+incdir+hw
hw/aer_pkg.sv
hw/pixel_level_0.sv
hw/pixel_groups_level_0.sv
hw/group_arbiter.sv
hw/aer_encoder.sv
hw/aer_readout_top.sv
test/aer_readout_chk.sv
test/aer_readout_tb.sv

/* Bender.yml */
package:
  name: aer_readout

export_include_dirs:
  - hw

sources:
  - files:
      - hw/aer_pkg.sv
      - hw/pixel_level_0.sv
      - hw/pixel_groups_level_0.sv
      - hw/group_arbiter.sv
      - hw/aer_encoder.sv
      - hw/aer_readout_top.sv
  - target: test
    files:
      - test/aer_readout_chk.sv
      - test/aer_readout_tb.sv

/* test/aer_readout_tb.sv */
// Testbench of the event sensor readout
// Raises pixel requests in batches from the stimulus file, models the pixels
// and checks every event against a scoreboard and the round-robin tile order
`timescale 1ns/100ps
`include "aer_cfg.svh"

module aer_readout_tb;

    import aer_pkg::*;

    localparam int SEED     = 86;
    localparam int GAP_MAX  = 8;                        // Idle cycles before a batch
    localparam int TURN_MAX = 8;                        // Upper bound of one tile turn

    logic                                       clk;
    logic                                       rst_n;
    pol_t [`AER_ROWS-1:0][`AER_COLS-1:0]        req_drv;       // Pixel array model
    logic [`AER_ROWS-1:0][`AER_COLS-1:0]        gnt_out;
    logic                                       ev_valid;
    pix_addr_t                                  ev_x;
    pix_addr_t                                  ev_y;
    pol_t                                       ev_pol;

    integer                              seed;
    int                                  n_batches;
    int                                  ev_row[$];     // Stimulus events
    int                                  ev_col[$];
    int                                  ev_pol_q[$];
    int                                  ev_batch[$];
    bit                                  stim_loaded;
    bit                                  any_raised;
    int unsigned                         cyc = 0;       // Cycle count
    int                                  events_seen;
    bit                                  exp_pend [`AER_ROWS][`AER_COLS];  // Scoreboard
    pol_t                                exp_pol  [`AER_ROWS][`AER_COLS];
    int unsigned                         raise_cyc[`AER_ROWS][`AER_COLS];
    logic [`AER_ROWS-1:0][`AER_COLS-1:0] gnt_seen;      // Grants of the last cycle
    logic [`AER_NUM_GROUPS-1:0]          tile_hist [4]; // Tile requests, newest first
    bit                                  in_turn;
    int                                  last_tile;
    int                                  last_loc;
    int unsigned                         turn_snap;     // Snapshot cycle of the turn

    aer_readout_top dut_i
    (
        .clk_i         (clk),
        .rst_n_i       (rst_n),
        .req_i         (req_drv),
        .gnt_out_o     (gnt_out),
        .event_valid_o (ev_valid),
        .event_x_o     (ev_x),
        .event_y_o     (ev_y),
        .event_pol_o   (ev_pol)
    );

    // ----------------------------------------------------------------------
    // Reporting and reference helpers
    // ----------------------------------------------------------------------
    task automatic fail_stop(input string line);
        $display("%s", line);
        $display("Checks failed");
        $fatal(1, "Run stopped after a failure");
    endtask

    task automatic compare(input logic [31:0] actual, input logic [31:0] expected,
                           input string what);
        if (actual !== expected)
            fail_stop($sformatf("ERROR at %0t: %s, got %0d expected %0d",
                                $time, what, actual, expected));
    endtask

    function automatic logic [`AER_NUM_GROUPS-1:0] tile_mask();
        logic [`AER_NUM_GROUPS-1:0] m;
        m = '0;
        for (int r = 0; r < `AER_ROWS; r++)
            for (int c = 0; c < `AER_COLS; c++)
                if (req_drv[r][c] != '0)
                    m[(r / `AER_GRP_SIZE) * `AER_GRP_COLS + c / `AER_GRP_SIZE] = 1'b1;
        return m;
    endfunction

    // First requesting tile after last in row-major order with last itself at the end
    function automatic int first_after(input logic [`AER_NUM_GROUPS-1:0] mask, input int last);
        int idx;
        for (int i = 1; i <= `AER_NUM_GROUPS; i++)
        begin
            idx = (last + i) % `AER_NUM_GROUPS;
            if (mask[idx])
                return idx;
        end
        return -1;
    endfunction

    function automatic bit pixel_busy(input int r, input int c);
        return exp_pend[r][c] || (req_drv[r][c] != '0);
    endfunction

    task automatic load_stimulus();
        int    fd;
        int    r;
        int    c;
        int    p;
        string line;
        fd = $fopen("test/aer_stimulus.txt", "r");
        if (fd == 0)
            fail_stop("Cannot open test/aer_stimulus.txt for reading");
        n_batches = 1;
        while (!$feof(fd))
        begin
            line = "";
            if ($fgets(line, fd) > 0)
            begin
                if (line.getc(0) == "-")
                    n_batches++;                        // Dash line closes a batch
                else if (line.getc(0) != "/" && $sscanf(line, "%d %d %d", r, c, p) == 3)
                begin
                    ev_row.push_back(r);
                    ev_col.push_back(c);
                    ev_pol_q.push_back(p);
                    ev_batch.push_back(n_batches - 1);
                end
            end
        end
        $fclose(fd);
        stim_loaded = 1'b1;
    endtask

    // Waits until no pixel of the batch is still owed a grant or an event
    task automatic raise_batch(input int b);
        bit busy;
        busy = 1'b1;
        while (busy)
        begin
            @(posedge clk);
            #1;
            busy = 1'b0;
            foreach (ev_row[i])
                if (ev_batch[i] == b && pixel_busy(ev_row[i], ev_col[i]))
                    busy = 1'b1;
        end
        foreach (ev_row[i])
        begin
            if (ev_batch[i] == b)
            begin
                req_drv[ev_row[i]][ev_col[i]]   = pol_t'(ev_pol_q[i]);
                exp_pol[ev_row[i]][ev_col[i]]   = pol_t'(ev_pol_q[i]);
                exp_pend[ev_row[i]][ev_col[i]]  = 1'b1;
                raise_cyc[ev_row[i]][ev_col[i]] = cyc;
                any_raised = 1'b1;
            end
        end
    endtask

    // ----------------------------------------------------------------------
    // Clock, cycle count, pixel model
    // ----------------------------------------------------------------------
    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;                          // 4 ns period
    end

    always @(posedge clk)
    begin
        cyc <= cyc + 1;
    end

    // Granted pixel drops its request on the next drive point
    initial
    begin
        forever
        begin
            @(posedge clk);
            #1;
            for (int r = 0; r < `AER_ROWS; r++)
                for (int c = 0; c < `AER_COLS; c++)
                    if (gnt_seen[r][c])
                        req_drv[r][c] = '0;
        end
    end

    // ----------------------------------------------------------------------
    // Monitor and scoreboard sampled mid-cycle
    // ----------------------------------------------------------------------
    always @(negedge clk)
    begin : monitor
        int ex;
        int ey;
        int tile;
        int loc;
        int pr;
        int pc;
        if (rst_n)
        begin
            compare(dut_i.u_chk.fail_cnt, 0, "bound protocol assertion failed");
            if (!any_raised)
            begin
                compare(ev_valid, 0, "event strobe before the first request");
                compare(|gnt_out, 0, "pixel grant before the first request");
            end
            for (int r = 0; r < `AER_ROWS; r++)
                for (int c = 0; c < `AER_COLS; c++)
                    if (gnt_out[r][c])
                        compare(req_drv[r][c] != '0, 1, "grant to a pixel without request");
            gnt_seen     = gnt_out;
            tile_hist[3] = tile_hist[2];                // Decision cycle of a new turn
            tile_hist[2] = tile_hist[1];
            tile_hist[1] = tile_hist[0];
            tile_hist[0] = tile_mask();
            if (ev_valid)
            begin
                ex   = ev_x;
                ey   = ev_y;
                tile = (ex / `AER_GRP_SIZE) * `AER_GRP_COLS + ey / `AER_GRP_SIZE;
                loc  = (ex % `AER_GRP_SIZE) * `AER_GRP_SIZE + ey % `AER_GRP_SIZE;
                if (!in_turn)
                begin
                    compare(tile, first_after(tile_hist[3], last_tile), "round-robin tile order");
                    in_turn   = 1'b1;
                    last_tile = tile;
                    last_loc  = -1;
                    turn_snap = cyc - 2;                // Event trails snapshot by 2 cycles
                end
                compare(tile, last_tile, "event outside the tile of this turn");
                compare(loc > last_loc, 1, "events of a turn out of row-major order");
                compare(exp_pend[ex][ey], 1, "event without a pending request");
                compare(ev_pol, exp_pol[ex][ey], "event polarity");
                compare(raise_cyc[ex][ey] <= turn_snap, 1, "late request served in the same turn");
                exp_pend[ex][ey] = 1'b0;
                last_loc         = loc;
                events_seen++;
            end
            else if (in_turn)
            begin
                in_turn = 1'b0;                         // Snapshot of the finished turn is empty
                for (int i = 0; i < `AER_GRP_SIZE; i++)
                begin
                    for (int j = 0; j < `AER_GRP_SIZE; j++)
                    begin
                        pr = (last_tile / `AER_GRP_COLS) * `AER_GRP_SIZE + i;
                        pc = (last_tile % `AER_GRP_COLS) * `AER_GRP_SIZE + j;
                        compare(exp_pend[pr][pc] && raise_cyc[pr][pc] <= turn_snap, 0,
                                "pixel of the snapshot left unserved");
                    end
                end
            end
        end
    end

    // ----------------------------------------------------------------------
    // Watchdog
    // ----------------------------------------------------------------------
    initial
    begin : watchdog
        int limit;
        wait (stim_loaded);
        limit = (ev_row.size() + 1) * `AER_NUM_GROUPS * TURN_MAX + n_batches * GAP_MAX + 100;
        repeat (limit) @(posedge clk);
        fail_stop($sformatf("Timeout after %0d cycles, not every request was served", limit));
    end

    // ----------------------------------------------------------------------
    // Main sequence
    // ----------------------------------------------------------------------
    initial
    begin : main
        int gap;
        rst_n       = 1'b0;
        req_drv     = '0;
        seed        = SEED;
        events_seen = 0;
        last_tile   = `AER_NUM_GROUPS - 1;              // Tile 0 is served first
        gnt_seen    = '0;
        for (int k = 0; k < 4; k++)
            tile_hist[k] = '0;
        load_stimulus();
        repeat (8) @(posedge clk);
        #1;
        rst_n = 1'b1;
        for (int b = 0; b < n_batches; b++)
        begin
            gap = $unsigned($random(seed)) % GAP_MAX;   // Lands batches mid-burst at times
            repeat (gap) @(posedge clk);
            raise_batch(b);
        end
        while (req_drv != '0)
            @(posedge clk);
        repeat (4) @(posedge clk);                      // Last events drain out
        #1;
        compare(dut_i.u_chk.fail_cnt, 0, "bound protocol assertion failed");
        compare(events_seen, ev_row.size(), "number of events");
        for (int r = 0; r < `AER_ROWS; r++)
        begin
            for (int c = 0; c < `AER_COLS; c++)
            begin
                compare(exp_pend[r][c], 0, "request never turned into an event");
            end
        end
        $display("All checks passed");
        $finish;
    end

endmodule

/* test/aer_readout_chk.sv */
// Protocol checks of the event sensor readout
// Grant and enable encoding, bus hold until release, event strobe in reset
`timescale 1ns/100ps
`include "aer_cfg.svh"

module aer_readout_chk
(
    input  logic                                        clk_i,      // System clock
    input  logic                                        rst_n_i,    // Sync reset, active low
    input  logic [`AER_ROWS-1:0][`AER_COLS-1:0]         gnt_i,      // Pixel grant pulses
    input  logic [`AER_GRP_ROWS-1:0][`AER_GRP_COLS-1:0] enable_i,   // Bus owner
    input  logic                                        release_i,  // Owner hands back
    input  logic                                        valid_i     // Event strobe
);

    int unsigned fail_cnt = 0;                          // Failed assertions so far

    a_gnt_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i) $onehot0(gnt_i))
    else
    begin
        $error("Pixel grant is not one-hot");
        fail_cnt++;
    end

    a_enable_onehot: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        $onehot0(enable_i))
    else
    begin
        $error("Tile enable is not one-hot");
        fail_cnt++;
    end

    // Owner keeps the bus until it pulses release
    a_enable_hold: assert property (@(posedge clk_i) disable iff (!rst_n_i)
        (enable_i != '0 && !release_i) |=> (enable_i == $past(enable_i)))
    else
    begin
        $error("Tile enable changed before release");
        fail_cnt++;
    end

    a_valid_reset: assert property (@(posedge clk_i) !rst_n_i |=> !valid_i)
    else
    begin
        $error("Event strobe high during reset");
        fail_cnt++;
    end

endmodule

bind aer_readout_top aer_readout_chk u_chk
(
    .clk_i     (clk_i),
    .rst_n_i   (rst_n_i),
    .gnt_i     (gnt_out_o),
    .enable_i  (grp_enable),
    .release_i (grp_release),
    .valid_i   (event_valid_o)
);

/* hw/aer_readout_top.sv */
// Event sensor readout top
// Tile grouping, round-robin bus arbiter and address-event encoder
`timescale 1ns/100ps
`include "aer_cfg.svh"

module aer_readout_top
(
    input  logic                                         clk_i,          // System clock
    input  logic                                         rst_n_i,        // Sync reset, active low
    input  aer_pkg::pol_t [`AER_ROWS-1:0][`AER_COLS-1:0] req_i,          // Pixel requests
    output logic [`AER_ROWS-1:0][`AER_COLS-1:0]          gnt_out_o,      // Pixel grant pulses
    output logic                                         event_valid_o,  // Event strobe
    output aer_pkg::pix_addr_t                           event_x_o,      // Pixel row
    output aer_pkg::pix_addr_t                           event_y_o,      // Pixel column
    output aer_pkg::pol_t                                event_pol_o     // ON and OFF bits
);

    import aer_pkg::*;

    logic [`AER_GRP_ROWS-1:0][`AER_GRP_COLS-1:0] grp_req;       // Idle tiles with requests
    logic [`AER_GRP_ROWS-1:0][`AER_GRP_COLS-1:0] grp_enable;    // Bus owner
    logic [`AER_GRP_SIZE-1:0][`AER_GRP_SIZE-1:0] grp_gnt;       // Owner's local grant
    loc_addr_t                                   grp_x;
    loc_addr_t                                   grp_y;
    logic                                        grp_release;

    pixel_groups_level_0 u_pixel_groups_level_0
    (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .req_i         (req_i),
        .enable_i      (grp_enable),
        .req_o         (grp_req),
        .gnt_out_o     (gnt_out_o),
        .gnt_o         (grp_gnt),
        .x_add_o       (grp_x),
        .y_add_o       (grp_y),
        .active_o      (),                              // Busy level, observation only
        .grp_release_o (grp_release)
    );

    group_arbiter u_group_arbiter
    (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .grp_req_i     (grp_req),
        .grp_release_i (grp_release),
        .grp_enable_o  (grp_enable)
    );

    aer_encoder u_aer_encoder
    (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .req_i         (req_i),
        .grp_enable_i  (grp_enable),
        .gnt_i         (grp_gnt),
        .x_loc_i       (grp_x),
        .y_loc_i       (grp_y),
        .event_valid_o (event_valid_o),
        .event_x_o     (event_x_o),
        .event_y_o     (event_y_o),
        .event_pol_o   (event_pol_o)
    );

endmodule

/* hw/aer_encoder.sv */
// Address-event encoder
// Joins the owner tile's position with the local grant address and emits a
// registered event with the pixel's polarity one cycle after the grant
`timescale 1ns/100ps
`include "aer_cfg.svh"

module aer_encoder
(
    input  logic                                         clk_i,          // System clock
    input  logic                                         rst_n_i,        // Sync reset, active low
    input  aer_pkg::pol_t [`AER_ROWS-1:0][`AER_COLS-1:0] req_i,          // Pixel requests
    input  logic [`AER_GRP_ROWS-1:0][`AER_GRP_COLS-1:0]  grp_enable_i,   // Bus owner, one-hot
    input  logic [`AER_GRP_SIZE-1:0][`AER_GRP_SIZE-1:0]  gnt_i,          // Owner's local grant
    input  aer_pkg::loc_addr_t                           x_loc_i,        // Local row
    input  aer_pkg::loc_addr_t                           y_loc_i,        // Local column
    output logic                                         event_valid_o,  // Event strobe
    output aer_pkg::pix_addr_t                           event_x_o,      // Pixel row
    output aer_pkg::pix_addr_t                           event_y_o,      // Pixel column
    output aer_pkg::pol_t                                event_pol_o     // ON and OFF bits
);

    import aer_pkg::*;

    logic [`AER_GRP_ADDR_W-1:0] grp_row;   // Row of the owner tile
    logic [`AER_GRP_ADDR_W-1:0] grp_col;   // Column of the owner tile
    pix_addr_t                  pix_x;
    pix_addr_t                  pix_y;
    logic                       fire;      // A pixel is granted this cycle

    always_comb
    begin
        grp_row = '0;
        grp_col = '0;
        for (int r = 0; r < `AER_GRP_ROWS; r++)
        begin
            for (int c = 0; c < `AER_GRP_COLS; c++)
            begin
                if (grp_enable_i[r][c])
                begin
                    grp_row = `AER_GRP_ADDR_W'(r);
                    grp_col = `AER_GRP_ADDR_W'(c);
                end
            end
        end
    end

    assign pix_x = {grp_row, x_loc_i};                  // Tile side is a power of two
    assign pix_y = {grp_col, y_loc_i};
    assign fire  = |gnt_i;

    // ----------------------------------------------------------------------
    // Output registers
    // ----------------------------------------------------------------------
    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
            event_valid_o <= 1'b0;
        else
            event_valid_o <= fire;
    end

    always_ff @(posedge clk_i)
    begin
        if (fire)
        begin
            event_x_o   <= pix_x;
            event_y_o   <= pix_y;
            event_pol_o <= req_i[pix_x][pix_y];        // Request still high in grant cycle
        end
    end

endmodule

/* hw/group_arbiter.sv */
// Round-robin owner of the shared event bus
// Enables one requesting tile at a time, starting after the last served
// tile in row-major order, and holds it until that tile releases
`timescale 1ns/100ps
`include "aer_cfg.svh"

module group_arbiter
(
    input  logic                                        clk_i,          // System clock
    input  logic                                        rst_n_i,        // Sync reset, active low
    input  logic [`AER_GRP_ROWS-1:0][`AER_GRP_COLS-1:0] grp_req_i,      // Tile requests
    input  logic                                        grp_release_i,  // Owner is done
    output logic [`AER_GRP_ROWS-1:0][`AER_GRP_COLS-1:0] grp_enable_o    // One-hot bus owner
);

    import aer_pkg::*;

    arb_state_e                  state_q;     // Arbiter FSM
    logic [`AER_GRP_IDX_W-1:0]   last_q;      // Last served tile, row-major
    logic [`AER_GRP_IDX_W-1:0]   next_idx;    // First requester after last_q
    logic [`AER_GRP_IDX_W-1:0]   cand;        // Tile under test in the search
    logic [`AER_NUM_GROUPS-1:0]  req_flat;    // Bit gr*COLS+gc is tile [gr][gc]
    logic [`AER_NUM_GROUPS-1:0]  enable_q;

    assign req_flat     = grp_req_i;
    assign grp_enable_o = enable_q;

    // ----------------------------------------------------------------------
    // Round-robin search
    // ----------------------------------------------------------------------
    // Walks from the farthest tile back to the nearest one, so the nearest
    // requester after last_q is the one left in next_idx
    always_comb
    begin
        next_idx = last_q;
        cand     = last_q;
        for (int i = `AER_NUM_GROUPS; i >= 1; i--)
        begin
            cand = last_q + `AER_GRP_IDX_W'(i);         // Wraps, last_q itself comes last
            if (req_flat[cand])
                next_idx = cand;
        end
    end

    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
        begin
            state_q  <= ARB_IDLE;
            last_q   <= '1;                             // Tile 0 goes first
            enable_q <= '0;
        end
        else
        begin
            case (state_q)
                ARB_IDLE:
                begin
                    if (|req_flat)
                    begin
                        state_q  <= ARB_BUSY;
                        last_q   <= next_idx;
                        enable_q <= `AER_NUM_GROUPS'(1) << next_idx;
                    end
                end
                default:
                begin
                    if (grp_release_i)
                    begin
                        state_q  <= ARB_IDLE;           // Re-arbitrate next cycle
                        enable_q <= '0;
                    end
                end
            endcase
        end
    end

endmodule

/* hw/pixel_groups_level_0.sv */
// First grouping level of the pixel array
// Cuts the array into 2x2 tiles, runs one tile arbiter per tile and selects
// the grant, address and release of the tile that owns the event bus
`timescale 1ns/100ps
`include "aer_cfg.svh"

module pixel_groups_level_0
(
    input  logic                                         clk_i,         // System clock
    input  logic                                         rst_n_i,       // Sync reset, active low
    input  aer_pkg::pol_t [`AER_ROWS-1:0][`AER_COLS-1:0] req_i,         // Pixel requests
    input  logic [`AER_GRP_ROWS-1:0][`AER_GRP_COLS-1:0]  enable_i,      // Bus owner, one-hot
    output logic [`AER_GRP_ROWS-1:0][`AER_GRP_COLS-1:0]  req_o,         // Tile requests
    output logic [`AER_ROWS-1:0][`AER_COLS-1:0]          gnt_out_o,     // Full-array grant
    output logic [`AER_GRP_SIZE-1:0][`AER_GRP_SIZE-1:0]  gnt_o,         // Owner's local grant
    output aer_pkg::loc_addr_t                           x_add_o,       // Owner's local row
    output aer_pkg::loc_addr_t                           y_add_o,       // Owner's local column
    output logic                                         active_o,      // Owner is serving
    output logic                                         grp_release_o  // Owner hands back
);

    import aer_pkg::*;

    logic [`AER_GRP_ROWS-1:0][`AER_GRP_COLS-1:0][`AER_GRP_SIZE-1:0][`AER_GRP_SIZE-1:0] tile_req;
    logic [`AER_GRP_ROWS-1:0][`AER_GRP_COLS-1:0][`AER_GRP_SIZE-1:0][`AER_GRP_SIZE-1:0] tile_gnt;
    loc_addr_t [`AER_GRP_ROWS-1:0][`AER_GRP_COLS-1:0] tile_x;        // Local rows per tile
    loc_addr_t [`AER_GRP_ROWS-1:0][`AER_GRP_COLS-1:0] tile_y;        // Local columns per tile
    logic [`AER_GRP_ROWS-1:0][`AER_GRP_COLS-1:0]      tile_active;
    logic [`AER_GRP_ROWS-1:0][`AER_GRP_COLS-1:0]      tile_release;

    // ----------------------------------------------------------------------
    // Tiling of requests and scatter of grants
    // ----------------------------------------------------------------------
    always_comb
    begin
        for (int gr = 0; gr < `AER_GRP_ROWS; gr++)
        begin
            for (int gc = 0; gc < `AER_GRP_COLS; gc++)
            begin
                for (int r = 0; r < `AER_GRP_SIZE; r++)
                begin
                    for (int c = 0; c < `AER_GRP_SIZE; c++)
                    begin
                        tile_req[gr][gc][r][c] =
                            |req_i[gr*`AER_GRP_SIZE + r][gc*`AER_GRP_SIZE + c];  // Either polarity
                        gnt_out_o[gr*`AER_GRP_SIZE + r][gc*`AER_GRP_SIZE + c] =
                            tile_gnt[gr][gc][r][c];
                    end
                end
            end
        end
    end

    for (genvar gr = 0; gr < `AER_GRP_ROWS; gr++)
    begin : g_row
        for (genvar gc = 0; gc < `AER_GRP_COLS; gc++)
        begin : g_col
            pixel_level_0 u_pixel_level_0
            (
                .clk_i         (clk_i),
                .rst_n_i       (rst_n_i),
                .enable_i      (enable_i[gr][gc]),
                .req_i         (tile_req[gr][gc]),
                .req_o         (req_o[gr][gc]),
                .gnt_o         (tile_gnt[gr][gc]),
                .x_add_o       (tile_x[gr][gc]),
                .y_add_o       (tile_y[gr][gc]),
                .active_o      (tile_active[gr][gc]),
                .grp_release_o (tile_release[gr][gc])
            );
        end
    end

    // ----------------------------------------------------------------------
    // One-hot select of the bus owner
    // ----------------------------------------------------------------------
    always_comb
    begin
        gnt_o         = '0;
        x_add_o       = '0;
        y_add_o       = '0;
        active_o      = 1'b0;
        grp_release_o = 1'b0;
        for (int gr = 0; gr < `AER_GRP_ROWS; gr++)
        begin
            for (int gc = 0; gc < `AER_GRP_COLS; gc++)
            begin
                if (enable_i[gr][gc])
                begin
                    gnt_o         = gnt_o | tile_gnt[gr][gc];  // At most one tile enabled
                    x_add_o       = x_add_o | tile_x[gr][gc];
                    y_add_o       = y_add_o | tile_y[gr][gc];
                    active_o      = active_o | tile_active[gr][gc];
                    grp_release_o = grp_release_o | tile_release[gr][gc];
                end
            end
        end
    end

endmodule

/* hw/pixel_level_0.sv */
// Pixel arbiter of one 2x2 tile
// Takes a snapshot of the pending pixels when the tile gets the bus, grants
// them one per cycle in row-major order and then pulses release for a cycle
`timescale 1ns/100ps
`include "aer_cfg.svh"

module pixel_level_0
(
    input  logic                                        clk_i,          // System clock
    input  logic                                        rst_n_i,        // Sync reset, active low
    input  logic                                        enable_i,       // Bus owned by this tile
    input  logic [`AER_GRP_SIZE-1:0][`AER_GRP_SIZE-1:0] req_i,          // Tile pixel requests
    output logic                                        req_o,          // Tile request upward
    output logic [`AER_GRP_SIZE-1:0][`AER_GRP_SIZE-1:0] gnt_o,          // One-hot pixel grant
    output aer_pkg::loc_addr_t                          x_add_o,        // Local row of grant
    output aer_pkg::loc_addr_t                          y_add_o,        // Local column of grant
    output logic                                        active_o,       // Turn in progress
    output logic                                        grp_release_o   // Last cycle of the turn
);

    import aer_pkg::*;

    grp_state_e                                  state_q;     // Tile FSM
    grp_state_e                                  state_d;
    logic [`AER_GRP_SIZE-1:0][`AER_GRP_SIZE-1:0] mask_q;      // Pixels still owed a grant
    logic [`AER_GRP_SIZE-1:0][`AER_GRP_SIZE-1:0] mask_left;   // Mask after this cycle's grant
    logic                                        pick_found;  // Grant already placed

    assign req_o         = (state_q == GRP_IDLE) && (|req_i);  // Hidden while serving
    assign active_o      = (state_q != GRP_IDLE);
    assign grp_release_o = (state_q == GRP_RELEASE);
    assign mask_left     = mask_q & ~gnt_o;

    // ----------------------------------------------------------------------
    // Fixed row-major pick from the snapshot
    // ----------------------------------------------------------------------
    always_comb
    begin
        gnt_o      = '0;
        x_add_o    = '0;
        y_add_o    = '0;
        pick_found = 1'b0;
        if (state_q == GRP_SERVE)
        begin
            for (int r = 0; r < `AER_GRP_SIZE; r++)
            begin
                for (int c = 0; c < `AER_GRP_SIZE; c++)
                begin
                    if (mask_q[r][c] && !pick_found)
                    begin
                        gnt_o[r][c] = 1'b1;             // First pending pixel wins
                        x_add_o     = loc_addr_t'(r);
                        y_add_o     = loc_addr_t'(c);
                        pick_found  = 1'b1;
                    end
                end
            end
        end
    end

    always_comb
    begin
        state_d = state_q;
        case (state_q)
            GRP_IDLE:
            begin
                if (enable_i)
                    state_d = (|req_i) ? GRP_SERVE : GRP_RELEASE;  // Empty snapshot hands back
            end
            GRP_SERVE:
            begin
                if (mask_left == '0)
                    state_d = GRP_RELEASE;              // Last snapshot pixel granted
            end
            default: state_d = GRP_IDLE;                // Release lasts one cycle
        endcase
    end

    always_ff @(posedge clk_i)
    begin
        if (!rst_n_i)
        begin
            state_q <= GRP_IDLE;
            mask_q  <= '0;
        end
        else
        begin
            state_q <= state_d;
            if (state_q == GRP_IDLE && enable_i)
                mask_q <= req_i;                        // Late requests wait for the next turn
            else if (state_q == GRP_SERVE)
                mask_q <= mask_left;
        end
    end

endmodule

/* hw/aer_pkg.sv */
// AER readout types
// Address and polarity types plus the FSM state encodings of the readout

`include "aer_cfg.svh"

package aer_pkg;

    // ----------------------------------------------------------------------
    // Addresses and polarity
    // ----------------------------------------------------------------------
    typedef logic [`AER_ADDR_W-1:0]   pix_addr_t;      // Full-array row or column
    typedef logic [`AER_LOC_W-1:0]    loc_addr_t;      // Row or column inside a tile
    typedef logic [`AER_POLARITY-1:0] pol_t;           // Bit 0 ON, bit 1 OFF

    // ----------------------------------------------------------------------
    // FSM states
    // ----------------------------------------------------------------------
    typedef enum logic [1:0]
    {
        GRP_IDLE,                                      // Waiting for bus ownership
        GRP_SERVE,                                     // Granting snapshot pixels
        GRP_RELEASE                                    // Handing the bus back
    } grp_state_e;

    typedef enum logic
    {
        ARB_IDLE,                                      // Picking the next tile
        ARB_BUSY                                       // One tile owns the bus
    } arb_state_e;

endpackage

/* hw/aer_cfg.svh */
// AER readout configuration
// Pixel array size, polarity width and group tiling of the event sensor readout
`ifndef AER_CFG_SVH
`define AER_CFG_SVH

// ----------------------------------------------------------------------
// Pixel array
// ----------------------------------------------------------------------
`define AER_ROWS        8                              // Pixel rows
`define AER_COLS        8                              // Pixel columns
`define AER_POLARITY    2                              // Bit 0 ON, bit 1 OFF
`define AER_ADDR_W      3                              // Pixel row or column address

// ----------------------------------------------------------------------
// Group tiling
// ----------------------------------------------------------------------
`define AER_GRP_SIZE    2                              // Side of one tile
`define AER_LOC_W       1                              // Address inside a tile
`define AER_GRP_ROWS    (`AER_ROWS / `AER_GRP_SIZE)    // Tile rows
`define AER_GRP_COLS    (`AER_COLS / `AER_GRP_SIZE)    // Tile columns
`define AER_NUM_GROUPS  16                             // Tiles in the array
`define AER_GRP_ADDR_W  2                              // Tile row or column index
`define AER_GRP_IDX_W   4                              // Row-major tile index

`endif
